// ==== design/core_pkg.sv ====
// Shared widths, encodings and stage bundles for the EX/MEM back end.
// Bubble encodings are all zero, so a cleared bundle is a legal bubble.
// Data memory is word addressed by address bits DMEM_AW+1:2.
// Upper address bits are ignored, so the memory aliases across the space.

`default_nettype none

package core_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = $clog2(DATA_W);

    // Data memory depth in words
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    // NOP must stay zero for the bubble
    typedef enum logic [2:0] {
        MEM_OP_NOP,
        MEM_OP_LW,
        MEM_OP_LB,
        MEM_OP_LBU,
        MEM_OP_SW,
        MEM_OP_SB
    } mem_op_e;

    typedef enum logic [2:0] {
        EXP_NONE,
        EXP_OVERFLOW,
        EXP_MISALIGN_LD,
        EXP_MISALIGN_ST
    } exp_code_e;

    ////////////////////////////////////////
    // Stage bundles
    ////////////////////////////////////////

    // From the ID/EX register
    typedef struct packed {
        logic                  en;
        logic [DATA_W-1:0]     pc;
        alu_op_e               alu_op;
        logic [DATA_W-1:0]     op_a;
        logic [DATA_W-1:0]     op_b;
        logic                  chk_ovf;     // add/sub trap, clear for addu/subu
        mem_op_e               mem_op;
        logic [DATA_W-1:0]     mem_wr_data;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic                  gpr_we;
    } id_bundle_t;

    // EX/MEM register contents
    typedef struct packed {
        logic                  en;
        exp_code_e             exp_code;
        logic [DATA_W-1:0]     pc;
        mem_op_e               mem_op;
        logic [DATA_W-1:0]     mem_wr_data;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic                  gpr_we;
        logic [DATA_W-1:0]     ex_out;      // ALU result, also the data address
    } ex_bundle_t;

    // Writeback bundle
    typedef struct packed {
        logic                  en;
        exp_code_e             exp_code;
        logic [DATA_W-1:0]     pc;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic                  gpr_we;
        logic [DATA_W-1:0]     wb_data;
    } wb_bundle_t;

    localparam ex_bundle_t EX_BUBBLE = '0;
    localparam wb_bundle_t WB_CLEAR  = '0;

endpackage

`default_nettype wire

// ==== design/alu.sv ====
// Purely combinational ALU.
// Shifts use only the low SHAMT_W bits of b.
// ovf flags signed overflow for add and sub only; trapping is decided upstream.

`timescale 1ns/1ps
`default_nettype none

module alu
    import core_pkg::*;
(
    input  alu_op_e           alu_op,
    input  logic [DATA_W-1:0] a,
    input  logic [DATA_W-1:0] b,
    output logic [DATA_W-1:0] result,
    output logic              ovf
);

    logic [DATA_W-1:0]  sum;
    logic [DATA_W-1:0]  diff;
    logic [SHAMT_W-1:0] shamt;
    logic               add_ovf;
    logic               sub_ovf;

    // Shared adder and subtractor results
    assign sum   = a + b;
    assign diff  = a - b;
    assign shamt = b[SHAMT_W-1:0];

    // Same operand signs, result sign flipped
    assign add_ovf = (a[DATA_W-1] == b[DATA_W-1]) && (sum[DATA_W-1] != a[DATA_W-1]);
    // Operand signs differ, result takes sign of b
    assign sub_ovf = (a[DATA_W-1] != b[DATA_W-1]) && (diff[DATA_W-1] != a[DATA_W-1]);

    always_comb begin
        result = '0;
        ovf    = 1'b0;
        case (alu_op)
            ALU_ADD: begin
                result = sum;
                ovf    = add_ovf;
            end
            ALU_SUB: begin
                result = diff;
                ovf    = sub_ovf;
            end
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            ALU_SLL:    result = a << shamt;
            ALU_SRL:    result = a >> shamt;
            // Arithmetic shift keeps the sign
            ALU_SRA:    result = $signed(a) >>> shamt;
            // Signed compare, result is 0 or 1
            ALU_SLT:    result = {{(DATA_W-1){1'b0}}, ($signed(a) < $signed(b))};
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/ex_stage.sv ====
// EX stage, combinational.
// Raises the overflow code only when chk_ovf is set on a valid item.
// A faulting item leaves with gpr_we low and mem_op NOP so MEM stays inert.
// gpr_we is also dropped for invalid items.

`timescale 1ns/1ps
`default_nettype none

module ex_stage
    import core_pkg::*;
(
    input  id_bundle_t id_in,
    output ex_bundle_t ex_next
);

    logic [DATA_W-1:0] alu_res;
    logic              alu_ovf;
    logic              ovf_trap;

    alu i_alu (
        .alu_op (id_in.alu_op),
        .a      (id_in.op_a),
        .b      (id_in.op_b),
        .result (alu_res),
        .ovf    (alu_ovf)
    );

    // Trap only for signed add/sub variants
    assign ovf_trap = id_in.en && id_in.chk_ovf && alu_ovf;

    always_comb begin
        ex_next.en          = id_in.en;
        ex_next.exp_code    = ovf_trap ? EXP_OVERFLOW : EXP_NONE;
        ex_next.pc          = id_in.pc;
        // Squash memory access of a faulting item
        ex_next.mem_op      = ovf_trap ? MEM_OP_NOP : id_in.mem_op;
        ex_next.mem_wr_data = id_in.mem_wr_data;
        ex_next.rd_addr     = id_in.rd_addr;
        ex_next.gpr_we      = id_in.en && id_in.gpr_we && !ovf_trap;
        // Wrapped result goes through even on overflow
        ex_next.ex_out      = alu_res;
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Invalid slot must not write a register or carry a fault
    always_comb begin
        if (!ex_next.en) begin
            assert (!ex_next.gpr_we && ex_next.exp_code == EXP_NONE)
            else $error("ex_stage: invalid slot carries gpr_we or exp_code");
        end
    end

endmodule

`default_nettype wire

// ==== design/ex_reg.sv ====
// EX/MEM pipeline register.
// stall holds every field and has priority over flush.
// An unstalled flush or a reset loads an all-zero bubble.

`timescale 1ns/1ps
`default_nettype none

module ex_reg
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       stall,
    input  logic       flush,
    input  ex_bundle_t ex_next,
    output ex_bundle_t ex_q
);

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_q <= EX_BUBBLE;
        end else if (!stall) begin
            // Flush kills the item that would load now
            if (flush) begin
                ex_q <= EX_BUBBLE;
            end else begin
                ex_q <= ex_next;
            end
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Flushed slot leaves no valid item behind
    a_flush_bubble: assert property (
        @(posedge clk) disable iff (rst)
        (!stall && flush) |=> !ex_q.en
    ) else $error("ex_reg: valid item after unstalled flush");

endmodule

`default_nettype wire

// ==== design/mem_stage.sv ====
// MEM stage with local data memory.
// Loads read the array combinationally; stores write at the clock edge.
// Word ops need a word-aligned ex_out; byte ops take any lane.
// Items that already carry a code are passed through unchecked.
// Memory is uninitialised, contents are undefined until first store.
// Nothing is written while stall is high.

`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       stall,
    input  ex_bundle_t ex_q,
    output wb_bundle_t wb_next
);

    logic [DATA_W-1:0]  dmem [DMEM_WORDS];

    logic [DMEM_AW-1:0] word_idx;
    logic [1:0]         lane;
    logic [DATA_W-1:0]  rd_word;
    logic [7:0]         rd_byte;
    logic               word_op;
    logic               is_store;
    logic               misalign;
    exp_code_e          exp_code;
    logic               mem_we;
    logic [DATA_W-1:0]  load_data;
    logic               fault_store;

    ////////////////////////////////////////
    // Address decode and fault check
    ////////////////////////////////////////

    assign word_idx = ex_q.ex_out[DMEM_AW+1:2];
    assign lane     = ex_q.ex_out[1:0];
    assign rd_word  = dmem[word_idx];
    assign rd_byte  = rd_word[lane*8 +: 8];

    assign word_op  = (ex_q.mem_op == MEM_OP_LW) || (ex_q.mem_op == MEM_OP_SW);
    assign is_store = (ex_q.mem_op == MEM_OP_SW) || (ex_q.mem_op == MEM_OP_SB);

    // EX fault wins, so only clean items are checked
    assign misalign = ex_q.en && (ex_q.exp_code == EXP_NONE) && word_op && (lane != 2'b00);

    always_comb begin
        exp_code = ex_q.exp_code;
        if (misalign) begin
            exp_code = (ex_q.mem_op == MEM_OP_LW) ? EXP_MISALIGN_LD : EXP_MISALIGN_ST;
        end
    end

    // Faulting store is suppressed
    assign mem_we = ex_q.en && !stall && is_store && (exp_code == EXP_NONE);

    ////////////////////////////////////////
    // Store path
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (mem_we) begin
            if (ex_q.mem_op == MEM_OP_SW) begin
                dmem[word_idx] <= ex_q.mem_wr_data;
            end else begin
                // Byte store hits one lane only
                dmem[word_idx][lane*8 +: 8] <= ex_q.mem_wr_data[7:0];
            end
        end
    end

    ////////////////////////////////////////
    // Load path and writeback bundle
    ////////////////////////////////////////

    always_comb begin
        case (ex_q.mem_op)
            MEM_OP_LW:  load_data = rd_word;
            MEM_OP_LB:  load_data = {{(DATA_W-8){rd_byte[7]}}, rd_byte};
            MEM_OP_LBU: load_data = {{(DATA_W-8){1'b0}}, rd_byte};
            // Non-loads forward the ALU result
            default:    load_data = ex_q.ex_out;
        endcase
    end

    always_comb begin
        wb_next.en       = ex_q.en;
        wb_next.exp_code = exp_code;
        wb_next.pc       = ex_q.pc;
        wb_next.rd_addr  = ex_q.rd_addr;
        wb_next.gpr_we   = ex_q.gpr_we && !misalign;
        // Faulting item reports its address
        wb_next.wb_data  = (exp_code == EXP_NONE) ? load_data : ex_q.ex_out;
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Valid store that carries any code
    assign fault_store = ex_q.en && is_store && (exp_code != EXP_NONE);

    // Addressed word keeps its old contents across the edge
    a_no_fault_write: assert property (
        @(posedge clk)
        fault_store |=> (dmem[$past(word_idx)] === $past(rd_word))
    ) else $error("mem_stage: memory write with exception pending");

endmodule

`default_nettype wire

// ==== design/mem_reg.sv ====
// MEM/WB pipeline register, drives the writeback bundle.
// Ignores flush; only stall holds it.

`timescale 1ns/1ps
`default_nettype none

module mem_reg
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       stall,
    input  wb_bundle_t wb_next,
    output wb_bundle_t wb_out
);

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_out <= WB_CLEAR;
        end else if (!stall) begin
            wb_out <= wb_next;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Writeback held steady while the chain is stalled
    a_stall_hold: assert property (
        @(posedge clk) disable iff (rst)
        stall |=> $stable(wb_out)
    ) else $error("mem_reg: wb_out changed across a stalled edge");

endmodule

`default_nettype wire

// ==== design/ex_mem_top.sv ====
// EX/MEM back end top level.
// Two-edge latency from id_in to wb_out, plus one edge per stalled edge.
// stall and flush are levels from an outside controller.
// No forwarding or hazard logic here.

`timescale 1ns/1ps
`default_nettype none

module ex_mem_top
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       stall,
    input  logic       flush,
    input  id_bundle_t id_in,
    output wb_bundle_t wb_out
);

    ex_bundle_t ex_next;
    ex_bundle_t ex_q;
    wb_bundle_t wb_next;

    // EX, combinational
    ex_stage i_ex_stage (
        .id_in   (id_in),
        .ex_next (ex_next)
    );

    // EX/MEM register, flushable
    ex_reg i_ex_reg (
        .clk     (clk),
        .rst     (rst),
        .stall   (stall),
        .flush   (flush),
        .ex_next (ex_next),
        .ex_q    (ex_q)
    );

    // MEM, store commits on the edge into mem_reg
    mem_stage i_mem_stage (
        .clk     (clk),
        .stall   (stall),
        .ex_q    (ex_q),
        .wb_next (wb_next)
    );

    // MEM/WB register
    mem_reg i_mem_reg (
        .clk     (clk),
        .rst     (rst),
        .stall   (stall),
        .wb_next (wb_next),
        .wb_out  (wb_out)
    );

endmodule

`default_nettype wire

// ==== include/ex_mem_ref.svh ====
// Reference model for the EX/MEM back end, for testbench use.
// Include inside a scope that imports core_pkg.
// Call once per item actually issued; flushed items must not be passed in.
// The model memory is updated on a clean store, in issue order.

`ifndef EX_MEM_REF_SVH
`define EX_MEM_REF_SVH

function automatic wb_bundle_t ex_mem_ref(
    input id_bundle_t         id,
    inout logic [DATA_W-1:0]  mem [DMEM_WORDS]
);
    wb_bundle_t         wb;
    logic [DATA_W-1:0]  res;
    logic [DATA_W:0]    wide;
    logic               ovf;
    logic [SHAMT_W-1:0] sh;
    logic [DMEM_AW-1:0] idx;
    logic [1:0]         lane;
    logic [7:0]         bval;
    mem_op_e            op;

    wb   = WB_CLEAR;
    ovf  = 1'b0;
    sh   = id.op_b[SHAMT_W-1:0];
    if (!id.en) begin
        return wb;
    end

    // ALU
    case (id.alu_op)
        ALU_ADD: begin
            // One extra sign bit, overflow when the top two bits differ
            wide = {id.op_a[DATA_W-1], id.op_a} + {id.op_b[DATA_W-1], id.op_b};
            res  = wide[DATA_W-1:0];
            ovf  = wide[DATA_W] != wide[DATA_W-1];
        end
        ALU_SUB: begin
            wide = {id.op_a[DATA_W-1], id.op_a} - {id.op_b[DATA_W-1], id.op_b};
            res  = wide[DATA_W-1:0];
            ovf  = wide[DATA_W] != wide[DATA_W-1];
        end
        ALU_AND:    res = id.op_a & id.op_b;
        ALU_OR:     res = id.op_a | id.op_b;
        ALU_XOR:    res = id.op_a ^ id.op_b;
        ALU_SLL:    res = id.op_a << sh;
        ALU_SRL:    res = id.op_a >> sh;
        ALU_SRA:    res = $signed(id.op_a) >>> sh;
        ALU_SLT:    res = ($signed(id.op_a) < $signed(id.op_b)) ? 1 : 0;
        ALU_PASS_B: res = id.op_b;
        default:    res = '0;
    endcase

    wb.en       = 1'b1;
    wb.pc       = id.pc;
    wb.rd_addr  = id.rd_addr;
    wb.gpr_we   = id.gpr_we;
    wb.exp_code = EXP_NONE;
    wb.wb_data  = res;
    op          = id.mem_op;

    // EX fault squashes the memory op
    if (id.chk_ovf && ovf) begin
        wb.exp_code = EXP_OVERFLOW;
        wb.gpr_we   = 1'b0;
        op          = MEM_OP_NOP;
    end

    idx  = res[DMEM_AW+1:2];
    lane = res[1:0];
    bval = mem[idx][lane*8 +: 8];

    if (wb.exp_code == EXP_NONE && lane != 2'b00 && (op == MEM_OP_LW || op == MEM_OP_SW)) begin
        wb.exp_code = (op == MEM_OP_LW) ? EXP_MISALIGN_LD : EXP_MISALIGN_ST;
        wb.gpr_we   = 1'b0;
        op          = MEM_OP_NOP;
    end

    // Clean memory access
    case (op)
        MEM_OP_LW:  wb.wb_data = mem[idx];
        MEM_OP_LB:  wb.wb_data = {{(DATA_W-8){bval[7]}}, bval};
        MEM_OP_LBU: wb.wb_data = {{(DATA_W-8){1'b0}}, bval};
        MEM_OP_SW:  mem[idx] = id.mem_wr_data;
        MEM_OP_SB:  mem[idx][lane*8 +: 8] = id.mem_wr_data[7:0];
        default:    wb.wb_data = res;
    endcase

    return wb;
endfunction

`endif

// ==== verif/tb_ex_mem.sv ====
// Testbench for the EX/MEM back end top level.
// Expected writeback bundles come from the reference model in ex_mem_ref.svh.
// Memory traffic stays inside a 16-word region that is fully written first.
// Inputs change on the falling edge, wb_out is sampled 2 ns after the rising edge.
// A watchdog stops the run if the tests overrun their cycle budget.

`timescale 1ns/1ps
`default_nettype none

module tb_ex_mem
    import core_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int N_ALU_EACH   = 8;
    localparam int N_ALU        = 10 * N_ALU_EACH;
    localparam int N_OVF        = 12;
    localparam int REGION_WORDS = 16;
    localparam int N_MEM_RAND   = 48;
    localparam int N_MEM        = REGION_WORDS + N_MEM_RAND;
    localparam int N_MISALIGN   = 5;
    localparam int N_STALL      = 200;
    localparam int N_TESTS      = 6;
    localparam int DRAIN_MAX    = 6;
    localparam int TOTAL_CYCLES = 2 + N_ALU + N_OVF + N_MEM + N_MISALIGN + N_STALL
                                  + N_TESTS * DRAIN_MAX;
    localparam int WATCHDOG_NS  = (TOTAL_CYCLES * 3 / 2 + RESET_CYCLES) * CLK_PERIOD;

    // Word index 32 and up, high bits only alias
    localparam logic [DATA_W-1:0] REGION_BASE = 32'h2000_0080;

    // Overflow corner cases, first three add, last three sub
    localparam logic [DATA_W-1:0] OVF_A [6] = '{
        32'h7fff_ffff, 32'h8000_0000, 32'h4000_0000,
        32'h8000_0000, 32'h7fff_ffff, 32'h0000_0000
    };
    localparam logic [DATA_W-1:0] OVF_B [6] = '{
        32'h0000_0001, 32'h8000_0000, 32'h4000_0000,
        32'h0000_0001, 32'hffff_ffff, 32'h8000_0000
    };

    logic       clk = 1'b0;
    logic       rst;
    logic       stall;
    logic       flush;
    id_bundle_t id_in;
    wb_bundle_t wb_out;

    integer            seed = 32'h3ce3;
    logic [DATA_W-1:0] model_mem [DMEM_WORDS];
    wb_bundle_t        exp_q [$];
    logic [DATA_W-1:0] next_pc;
    int                errors;
    int                errors_at_start;
    int                tests_passed;
    int                tests_failed;

    // Checker sampling state
    logic              chk_stall;
    logic              chk_rst;
    wb_bundle_t        wb_prev;

    `include "ex_mem_ref.svh"

    ex_mem_top i_dut (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .flush  (flush),
        .id_in  (id_in),
        .wb_out (wb_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    // Valid item with random operands and a fresh pc
    task automatic new_item(output id_bundle_t it);
        logic [31:0] r;
        r              = next_rand();
        it             = '0;
        it.en          = 1'b1;
        it.pc          = next_pc;
        it.rd_addr     = r[REG_ADDR_W-1:0];
        it.gpr_we      = 1'b1;
        it.op_a        = next_rand();
        it.op_b        = next_rand();
        it.mem_wr_data = next_rand();
        next_pc        = next_pc + 4;
    endtask

    function automatic logic [DATA_W-1:0] region_addr(input logic [31:0] r, input logic aligned);
        logic [5:0] off;
        off = aligned ? {r[3:0], 2'b00} : r[5:0];
        return REGION_BASE + {{(DATA_W-6){1'b0}}, off};
    endfunction

    // Address built as base plus small offset through the ALU adder
    task automatic mem_item(input mem_op_e op, input logic [DATA_W-1:0] addr,
                            output id_bundle_t it);
        logic [31:0] r;
        new_item(it);
        r         = next_rand();
        it.alu_op = ALU_ADD;
        it.op_b   = {{(DATA_W-6){1'b0}}, r[5:0]};
        it.op_a   = addr - it.op_b;
        it.mem_op = op;
        it.gpr_we = (op == MEM_OP_LW) || (op == MEM_OP_LB) || (op == MEM_OP_LBU);
    endtask

    task automatic random_mem_item(output id_bundle_t it);
        logic [31:0] r;
        mem_op_e     op;
        r = next_rand();
        case (r % 5)
            0:       op = MEM_OP_SW;
            1:       op = MEM_OP_SB;
            2:       op = MEM_OP_LW;
            3:       op = MEM_OP_LB;
            default: op = MEM_OP_LBU;
        endcase
        // Word ops stay aligned here, byte ops hit any lane
        mem_item(op, region_addr(next_rand(), (op == MEM_OP_SW) || (op == MEM_OP_LW)), it);
    endtask

    task automatic random_alu_item(output id_bundle_t it);
        logic [31:0] r;
        new_item(it);
        r         = next_rand();
        it.alu_op = alu_op_e'(4'(r % 10));
    endtask

    // Drive one cycle; only consumed valid items are expected
    task automatic issue(input id_bundle_t it, input logic stall_v, input logic flush_v);
        @(negedge clk);
        id_in = it;
        stall = stall_v;
        flush = flush_v;
        if (it.en && !stall_v && !flush_v) begin
            exp_q.push_back(ex_mem_ref(it, model_mem));
        end
    endtask

    // Idle cycles until all expected items came out
    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_MAX) begin
            issue('0, 1'b0, 1'b0);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("[ERROR] %0t ns: %0d expected items never appeared on wb_out",
                     $time, exp_q.size());
            errors++;
            exp_q.delete();
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("[TEST] %s: ok", name);
        end else begin
            tests_failed++;
            $display("[TEST] %s: FAILED with %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    ////////////////////////////////////////
    // Checker
    ////////////////////////////////////////

    task automatic compare_wb(input wb_bundle_t exp_wb, input wb_bundle_t act);
        if (act.exp_code !== exp_wb.exp_code) begin
            $display("[ERROR] %0t ns: wb_out.exp_code expected %s actual %s",
                     $time, exp_wb.exp_code.name(), act.exp_code.name());
            errors++;
        end
        if (act.pc !== exp_wb.pc) begin
            $display("[ERROR] %0t ns: wb_out.pc expected %h actual %h",
                     $time, exp_wb.pc, act.pc);
            errors++;
        end
        if (act.rd_addr !== exp_wb.rd_addr) begin
            $display("[ERROR] %0t ns: wb_out.rd_addr expected %h actual %h",
                     $time, exp_wb.rd_addr, act.rd_addr);
            errors++;
        end
        if (act.gpr_we !== exp_wb.gpr_we) begin
            $display("[ERROR] %0t ns: wb_out.gpr_we expected %b actual %b",
                     $time, exp_wb.gpr_we, act.gpr_we);
            errors++;
        end
        if (act.wb_data !== exp_wb.wb_data) begin
            $display("[ERROR] %0t ns: wb_out.wb_data expected %h actual %h",
                     $time, exp_wb.wb_data, act.wb_data);
            errors++;
        end
    endtask

    // stall and rst taken at the edge, wb_out read once it settled
    always @(posedge clk) begin
        chk_stall = stall;
        chk_rst   = rst;
        #2;
        if (!chk_rst) begin
            if (chk_stall) begin
                if (wb_out !== wb_prev) begin
                    $display("[ERROR] %0t ns: wb_out changed on a stalled edge, was %h now %h",
                             $time, wb_prev, wb_out);
                    errors++;
                end
            end else if (wb_out.en) begin
                if (exp_q.size() == 0) begin
                    $display("[ERROR] %0t ns: wb_out shows an item (pc %h) nobody issued",
                             $time, wb_out.pc);
                    errors++;
                end else begin
                    compare_wb(exp_q.pop_front(), wb_out);
                end
            end
        end
        wb_prev = wb_out;
    end

    ////////////////////////////////////////
    // Watchdog
    ////////////////////////////////////////

    initial begin
        #(WATCHDOG_NS);
        $display("[WATCHDOG] run did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        id_bundle_t        it;
        logic [31:0]       r;
        logic [DATA_W-1:0] addr;

        rst             = 1'b1;
        stall           = 1'b0;
        flush           = 1'b0;
        id_in           = '0;
        next_pc         = 32'h0000_1000;
        errors          = 0;
        errors_at_start = 0;
        tests_passed    = 0;
        tests_failed    = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Reset state of the writeback bundle
        if (wb_out.en !== 1'b0) begin
            $display("[ERROR] %0t ns: wb_out.en expected 0 actual %b", $time, wb_out.en);
            errors++;
        end
        if (wb_out.gpr_we !== 1'b0) begin
            $display("[ERROR] %0t ns: wb_out.gpr_we expected 0 actual %b", $time, wb_out.gpr_we);
            errors++;
        end
        if (wb_out.exp_code !== EXP_NONE) begin
            $display("[ERROR] %0t ns: wb_out.exp_code expected EXP_NONE actual %s",
                     $time, wb_out.exp_code.name());
            errors++;
        end
        finish_test("reset");

        // All ten ALU ops, overflow never traps
        for (int k = 0; k < 10; k++) begin
            for (int j = 0; j < N_ALU_EACH; j++) begin
                new_item(it);
                it.alu_op = alu_op_e'(4'(k));
                issue(it, 1'b0, 1'b0);
            end
        end
        drain();
        finish_test("alu");

        // Same operands trapping and wrapping
        for (int k = 0; k < 6; k++) begin
            for (int c = 0; c < 2; c++) begin
                new_item(it);
                it.alu_op  = (k < 3) ? ALU_ADD : ALU_SUB;
                it.op_a    = OVF_A[k];
                it.op_b    = OVF_B[k];
                it.chk_ovf = (c == 0);
                issue(it, 1'b0, 1'b0);
            end
        end
        drain();
        finish_test("overflow");

        // Fill the region, then mixed stores and loads
        for (int w = 0; w < REGION_WORDS; w++) begin
            mem_item(MEM_OP_SW, REGION_BASE + 4 * w, it);
            issue(it, 1'b0, 1'b0);
        end
        for (int k = 0; k < N_MEM_RAND; k++) begin
            random_mem_item(it);
            issue(it, 1'b0, 1'b0);
        end
        drain();
        finish_test("memory");

        // Faulting word ops on word 3, then an aligned readback
        addr = REGION_BASE + 32'd12;
        mem_item(MEM_OP_LW, addr + 1, it);
        issue(it, 1'b0, 1'b0);
        mem_item(MEM_OP_SW, addr + 2, it);
        it.mem_wr_data = 32'hdead_beef;
        issue(it, 1'b0, 1'b0);
        mem_item(MEM_OP_SW, addr + 3, it);
        issue(it, 1'b0, 1'b0);
        mem_item(MEM_OP_LW, addr, it);
        issue(it, 1'b0, 1'b0);
        mem_item(MEM_OP_LBU, addr + 2, it);
        issue(it, 1'b0, 1'b0);
        drain();
        finish_test("misaligned");

        // Random stall about 1 in 4, flush 3 in 16, some bubbles
        for (int k = 0; k < N_STALL; k++) begin
            r = next_rand();
            if (r[8]) begin
                random_alu_item(it);
            end else begin
                random_mem_item(it);
            end
            if (r[11:9] == 3'b000) begin
                it.en = 1'b0;
            end
            issue(it, r[1:0] == 2'b00, r[7:4] < 4'd3);
        end
        drain();
        finish_test("stall_flush");

        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
design/core_pkg.sv
design/alu.sv
design/ex_stage.sv
design/ex_reg.sv
design/mem_stage.sv
design/mem_reg.sv
design/ex_mem_top.sv
verif/tb_ex_mem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the EX/MEM testbench with Verilator.
# Fails on a build or run error, or when the log holds the fail message.

set -o pipefail

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_ex_mem -f tb.f -o tb_ex_mem_sim \
    && ./obj_dir/tb_ex_mem_sim 2>&1 | tee "$LOG" \
    || { echo "run_sim: build or run error"; exit 1; }

grep -q "Simulation failed" "$LOG" \
    && { echo "run_sim: FAIL"; exit 1; } \
    || { echo "run_sim: PASS"; exit 0; }
